//--- files.f
+incdir+src
src/wb_pkg.sv
src/wb_stage.sv
src/commit_ctrl.sv
src/reg_file.sv
src/csr_file.sv
src/wb_top.sv
tests/wb_clk_gen.sv
tests/wb_tb.sv

//--- src/commit_ctrl.sv
`default_nettype none

`include "wb_settings.svh"

module commit_ctrl (
    input  wb_pkg::bundle_t     bundle_i,
    input  logic [`WB_XLEN-1:0] era_i,
    input  logic [`WB_XLEN-1:0] eentry_i,
    output wb_pkg::retire_t     retire_o,
    output wb_pkg::exc_req_t    exc_req_o,
    output wb_pkg::redirect_t   redirect_o
);

    localparam logic [`WB_XLEN-1:0] INSN_BYTES = 4;

    logic [1:0]    evt;    // slot carries a redirecting event
    logic [1:0]    live;   // slot reaches commit
    logic [1:0]    redir;
    logic          sel;
    wb_pkg::slot_t sel_slot;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            evt[i] = bundle_i.slot[i].exc | bundle_i.slot[i].ertn | bundle_i.slot[i].priv;
        end

        live[0]  = bundle_i.slot[0].valid;
        redir[0] = live[0] & evt[0];
        live[1]  = bundle_i.slot[1].valid & ~redir[0];  // younger slot killed
        redir[1] = live[1] & evt[1];

        // an excepting slot writes nothing
        for (int i = 0; i < 2; i++) begin
            retire_o.reg_we[i] = live[i] & ~bundle_i.slot[i].exc & bundle_i.slot[i].reg_we;
            retire_o.csr_we[i] = live[i] & ~bundle_i.slot[i].exc & bundle_i.slot[i].csr_we;
        end
    end

    assign sel      = ~redir[0];  // oldest redirecting slot
    assign sel_slot = bundle_i.slot[sel];

    always_comb begin
        redirect_o = '0;
        if (|redir) begin
            redirect_o.valid = 1'b1;
            if (sel_slot.exc) begin
                redirect_o.pc = eentry_i;
            end else if (sel_slot.ertn) begin
                redirect_o.pc = era_i;
            end else begin
                redirect_o.pc = sel_slot.pc + INSN_BYTES;  // refetch next
            end
        end
    end

    always_comb begin
        exc_req_o.take  = (|redir) & sel_slot.exc;
        exc_req_o.ertn  = (|redir) & ~sel_slot.exc & sel_slot.ertn;
        exc_req_o.ecode = sel_slot.ecode;
        exc_req_o.epc   = sel_slot.pc;
    end

endmodule

`default_nettype wire

//--- src/csr_file.sv
`default_nettype none

`include "wb_settings.svh"

module csr_file (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [1:0]            we_i,
    input  logic [`WB_CSR_AW-1:0] waddr0_i,
    input  logic [`WB_CSR_AW-1:0] waddr1_i,
    input  logic [`WB_XLEN-1:0]   wdata0_i,
    input  logic [`WB_XLEN-1:0]   wdata1_i,
    input  wb_pkg::exc_req_t      exc_req_i,
    input  logic                  llbit_set_i,
    input  logic [`WB_CSR_AW-1:0] raddr_i,
    output logic [`WB_XLEN-1:0]   rdata_o,
    output logic [`WB_XLEN-1:0]   era_o,
    output logic [`WB_XLEN-1:0]   eentry_o,
    output logic                  llbit_o
);

    wb_pkg::csr_word_u     crmd_q;
    wb_pkg::csr_word_u     prmd_q;
    logic [`WB_XLEN-1:0]   era_q;
    logic [`WB_XLEN-1:0]   estat_q;
    logic [`WB_XLEN-1:0]   eentry_q;
    logic                  llbit_q;

    logic [`WB_CSR_AW-1:0] waddr [2];
    logic [`WB_XLEN-1:0]   wdata [2];

    assign waddr[0] = waddr0_i;
    assign waddr[1] = waddr1_i;
    assign wdata[0] = wdata0_i;
    assign wdata[1] = wdata1_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            crmd_q.raw <= `WB_CRMD_RESET;
            prmd_q.raw <= '0;
            era_q      <= '0;
            estat_q    <= '0;
            eentry_q   <= `WB_EENTRY_RESET;
            llbit_q    <= 1'b0;
        end else begin
            if (llbit_set_i) begin
                llbit_q <= 1'b1;
            end

            // software writes, slot 1 last so it wins
            for (int p = 0; p < 2; p++) begin
                if (we_i[p]) begin
                    case (waddr[p])
                        `WB_CSR_CRMD:   crmd_q.raw   <= wdata[p];
                        `WB_CSR_PRMD:   prmd_q.raw   <= wdata[p];
                        `WB_CSR_ESTAT:  estat_q[1:0] <= wdata[p][1:0];  // only swi bits
                        `WB_CSR_ERA:    era_q        <= wdata[p];
                        `WB_CSR_EENTRY: eentry_q     <= wdata[p];
                        `WB_CSR_LLBCTL: begin
                            if (wdata[p][1]) begin
                                llbit_q <= 1'b0;  // wcllb
                            end
                        end
                        default: ;
                    endcase
                end
            end

            // exception entry and ertn take precedence over the writes above
            if (exc_req_i.take) begin
                prmd_q.mode.plv <= crmd_q.mode.plv;
                prmd_q.mode.ie  <= crmd_q.mode.ie;
                crmd_q.mode.plv <= 2'b00;
                crmd_q.mode.ie  <= 1'b0;
                era_q           <= exc_req_i.epc;
                estat_q[16 +: `WB_ECODE_W] <= exc_req_i.ecode;
            end else if (exc_req_i.ertn) begin
                crmd_q.mode.plv <= prmd_q.mode.plv;
                crmd_q.mode.ie  <= prmd_q.mode.ie;
                llbit_q         <= 1'b0;
            end
        end
    end

    always_comb begin
        case (raddr_i)
            `WB_CSR_CRMD:   rdata_o = crmd_q.raw;
            `WB_CSR_PRMD:   rdata_o = prmd_q.raw;
            `WB_CSR_ESTAT:  rdata_o = estat_q;
            `WB_CSR_ERA:    rdata_o = era_q;
            `WB_CSR_EENTRY: rdata_o = eentry_q;
            `WB_CSR_LLBCTL: rdata_o = {{(`WB_XLEN-1){1'b0}}, llbit_q};  // rollb
            default:        rdata_o = '0;
        endcase
    end

    assign era_o    = era_q;
    assign eentry_o = eentry_q;
    assign llbit_o  = llbit_q;

endmodule

`default_nettype wire

//--- src/reg_file.sv
`default_nettype none

`include "wb_settings.svh"

module reg_file (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic [1:0]          we_i,
    input  logic [4:0]          waddr0_i,
    input  logic [4:0]          waddr1_i,
    input  logic [`WB_XLEN-1:0] wdata0_i,
    input  logic [`WB_XLEN-1:0] wdata1_i,
    input  logic [4:0]          raddr_i,
    output logic [`WB_XLEN-1:0] rdata_o
);

    logic [`WB_XLEN-1:0] regs [`WB_NREG];
    logic [1:0]          wr_ok;

    // r0 is hardwired
    assign wr_ok[0] = we_i[0] & (waddr0_i != 5'd0);
    assign wr_ok[1] = we_i[1] & (waddr1_i != 5'd0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `WB_NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_ok[0]) begin
                regs[waddr0_i] <= wdata0_i;
            end
            if (wr_ok[1]) begin
                regs[waddr1_i] <= wdata1_i;  // younger slot wins on a clash
            end
        end
    end

    assign rdata_o = regs[raddr_i];

endmodule

`default_nettype wire

//--- src/wb_pkg.sv
`default_nettype none

`include "wb_settings.svh"

package wb_pkg;

    // one instruction leaving the memory stage
    typedef struct packed {
        logic                        valid;
        logic                        reg_we;
        logic [$clog2(`WB_NREG)-1:0] reg_addr;
        logic [`WB_XLEN-1:0]         reg_data;
        logic                        csr_we;
        logic [`WB_CSR_AW-1:0]       csr_addr;
        logic [`WB_XLEN-1:0]         csr_data;
        logic                        is_ll;
        logic                        is_sc;
        logic                        exc;
        logic [`WB_ECODE_W-1:0]      ecode;
        logic [`WB_XLEN-1:0]         pc;
        logic                        ertn;
        logic                        priv;  // refetch after retire
    } slot_t;

    typedef struct packed {
        slot_t [1:0] slot;  // slot 0 is older
    } bundle_t;

    typedef struct packed {
        logic [1:0] reg_we;
        logic [1:0] csr_we;
    } retire_t;

    typedef struct packed {
        logic                valid;
        logic [`WB_XLEN-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic                   take;
        logic [`WB_ECODE_W-1:0] ecode;
        logic [`WB_XLEN-1:0]    epc;
        logic                   ertn;
    } exc_req_t;

    typedef struct packed {
        logic [`WB_XLEN-4:0] upper;
        logic                ie;
        logic [1:0]          plv;
    } csr_mode_t;

    // crmd and prmd share the plv/ie layout
    typedef union packed {
        logic [`WB_XLEN-1:0] raw;
        csr_mode_t           mode;
    } csr_word_u;

endpackage

`default_nettype wire

//--- src/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// datapath widths
`define WB_XLEN    32
`define WB_NREG    32
`define WB_CSR_AW  14
`define WB_ECODE_W 7

// csr addresses
`define WB_CSR_CRMD   14'h000
`define WB_CSR_PRMD   14'h001
`define WB_CSR_ESTAT  14'h005
`define WB_CSR_ERA    14'h006
`define WB_CSR_EENTRY 14'h00c
`define WB_CSR_LLBCTL 14'h060

`define WB_CRMD_RESET   32'h0000_0008 // plv 0, ie 0, da 1
`define WB_EENTRY_RESET 32'h1c00_8000

`endif

//--- src/wb_stage.sv
`default_nettype none

module wb_stage (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            pause_i,
    input  logic            flush_i,
    input  logic            uncache_i,
    input  wb_pkg::bundle_t bundle_i,
    output wb_pkg::bundle_t bundle_o,
    output logic            llbit_set_o
);

    wb_pkg::bundle_t bundle_q;
    logic [1:0]      valid_q;
    logic [1:0]      ll_hit;
    logic            drop;

    assign drop = pause_i | flush_i;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            ll_hit[i] = bundle_i.slot[i].valid & bundle_i.slot[i].is_ll;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q     <= 2'b00;
            llbit_set_o <= 1'b0;
        end else if (drop) begin
            valid_q     <= 2'b00;  // empty bundle
            llbit_set_o <= 1'b0;
        end else begin
            valid_q[0]  <= bundle_i.slot[0].valid;
            valid_q[1]  <= bundle_i.slot[1].valid;
            llbit_set_o <= (|ll_hit) & ~uncache_i;  // uncached ll never sets it
        end
    end

    always_ff @(posedge clk) begin
        if (!drop) begin
            bundle_q <= bundle_i;
        end
    end

    always_comb begin
        bundle_o               = bundle_q;
        bundle_o.slot[0].valid = valid_q[0];
        bundle_o.slot[1].valid = valid_q[1];
    end

endmodule

`default_nettype wire

//--- src/wb_top.sv
`default_nettype none

`include "wb_settings.svh"

module wb_top (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  pause_i,
    input  logic                  flush_i,
    input  logic                  uncache_i,
    input  wb_pkg::bundle_t       commit_i,
    input  logic [4:0]            gpr_raddr_i,
    output logic [`WB_XLEN-1:0]   gpr_rdata_o,
    input  logic [`WB_CSR_AW-1:0] csr_raddr_i,
    output logic [`WB_XLEN-1:0]   csr_rdata_o,
    output logic                  llbit_o,
    output wb_pkg::redirect_t     redirect_o
);

    wb_pkg::bundle_t     wb_q;
    logic                llbit_set;
    wb_pkg::retire_t     retire;
    wb_pkg::exc_req_t    exc_req;
    logic [`WB_XLEN-1:0] era;
    logic [`WB_XLEN-1:0] eentry;

    wb_stage wb_stage_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pause_i     (pause_i),
        .flush_i     (flush_i),
        .uncache_i   (uncache_i),
        .bundle_i    (commit_i),
        .bundle_o    (wb_q),
        .llbit_set_o (llbit_set)
    );

    commit_ctrl commit_ctrl_i (
        .bundle_i   (wb_q),
        .era_i      (era),
        .eentry_i   (eentry),
        .retire_o   (retire),
        .exc_req_o  (exc_req),
        .redirect_o (redirect_o)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (retire.reg_we),
        .waddr0_i (wb_q.slot[0].reg_addr),
        .waddr1_i (wb_q.slot[1].reg_addr),
        .wdata0_i (wb_q.slot[0].reg_data),
        .wdata1_i (wb_q.slot[1].reg_data),
        .raddr_i  (gpr_raddr_i),
        .rdata_o  (gpr_rdata_o)
    );

    csr_file csr_file_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .we_i        (retire.csr_we),
        .waddr0_i    (wb_q.slot[0].csr_addr),
        .waddr1_i    (wb_q.slot[1].csr_addr),
        .wdata0_i    (wb_q.slot[0].csr_data),
        .wdata1_i    (wb_q.slot[1].csr_data),
        .exc_req_i   (exc_req),
        .llbit_set_i (llbit_set),
        .raddr_i     (csr_raddr_i),
        .rdata_o     (csr_rdata_o),
        .era_o       (era),
        .eentry_o    (eentry),
        .llbit_o     (llbit_o)
    );

endmodule

`default_nettype wire

//--- tests/wb_clk_gen.sv
`default_nettype none

module wb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;  // 4 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        #1 arst_n_o = 1'b1;  // released off the edge
    end

endmodule

`default_nettype wire

//--- tests/wb_tb.sv
`default_nettype none

`include "wb_settings.svh"

module wb_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         RESET_TIMEOUT = 40;  // cycles
    localparam logic [2:0] CTL_NONE      = 3'b000;
    localparam logic [2:0] CTL_PAUSE     = 3'b001;
    localparam logic [2:0] CTL_FLUSH     = 3'b010;
    localparam logic [2:0] CTL_UNCACHE   = 3'b100;
    localparam logic       RD_GPR        = 1'b0;
    localparam logic       RD_CSR        = 1'b1;

    typedef struct packed {
        wb_pkg::bundle_t       b;
        logic [2:0]            ctl;  // uncache, flush, pause
        logic                  rd_csr;
        logic [`WB_CSR_AW-1:0] rd_addr;
        logic                  exp_valid;
        logic [`WB_XLEN-1:0]   exp_pc;
        logic [`WB_XLEN-1:0]   exp_rd;
        logic                  exp_llbit;
    } entry_t;

    logic                  clk;
    logic                  arst_n;
    logic                  pause;
    logic                  flush;
    logic                  uncache;
    wb_pkg::bundle_t       commit;
    logic [4:0]            gpr_raddr;
    logic [`WB_XLEN-1:0]   gpr_rdata;
    logic [`WB_CSR_AW-1:0] csr_raddr;
    logic [`WB_XLEN-1:0]   csr_rdata;
    logic                  llbit;
    wb_pkg::redirect_t     redirect;

    entry_t table_q[$];
    string  name_q[$];
    integer seed = 32'hb4b0_60a8;
    int     n_err = 0;
    int     n_bad_tests = 0;

    // golden model state
    logic [`WB_XLEN-1:0] m_gpr [`WB_NREG];
    logic [`WB_XLEN-1:0] m_crmd;
    logic [`WB_XLEN-1:0] m_prmd;
    logic [`WB_XLEN-1:0] m_era;
    logic [`WB_XLEN-1:0] m_estat;
    logic [`WB_XLEN-1:0] m_eentry;
    logic                m_llbit;

    wb_clk_gen clk_gen_i (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    wb_top dut_i (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .pause_i     (pause),
        .flush_i     (flush),
        .uncache_i   (uncache),
        .commit_i    (commit),
        .gpr_raddr_i (gpr_raddr),
        .gpr_rdata_o (gpr_rdata),
        .csr_raddr_i (csr_raddr),
        .csr_rdata_o (csr_rdata),
        .llbit_o     (llbit),
        .redirect_o  (redirect)
    );

    function automatic wb_pkg::slot_t reg_slot(input logic [4:0] addr,
                                               input logic [`WB_XLEN-1:0] pc);
        wb_pkg::slot_t s;
        s          = '0;
        s.valid    = 1'b1;
        s.reg_we   = 1'b1;
        s.reg_addr = addr;
        s.reg_data = $random(seed);
        s.pc       = pc;
        return s;
    endfunction

    function automatic wb_pkg::slot_t csr_slot(input logic [`WB_CSR_AW-1:0] addr,
                                               input logic [`WB_XLEN-1:0] data);
        wb_pkg::slot_t s;
        s          = '0;
        s.valid    = 1'b1;
        s.csr_we   = 1'b1;
        s.csr_addr = addr;
        s.csr_data = data;
        s.pc       = 32'h1c00_1000;
        return s;
    endfunction

    function automatic logic [`WB_XLEN-1:0] model_read(input logic rd_csr,
                                                       input logic [`WB_CSR_AW-1:0] addr);
        if (!rd_csr) begin
            return m_gpr[addr[4:0]];
        end
        case (addr)
            `WB_CSR_CRMD:   return m_crmd;
            `WB_CSR_PRMD:   return m_prmd;
            `WB_CSR_ESTAT:  return m_estat;
            `WB_CSR_ERA:    return m_era;
            `WB_CSR_EENTRY: return m_eentry;
            `WB_CSR_LLBCTL: return {{(`WB_XLEN-1){1'b0}}, m_llbit};
            default:        return '0;
        endcase
    endfunction

    task automatic model_csr_write(input logic [`WB_CSR_AW-1:0] addr,
                                   input logic [`WB_XLEN-1:0] data);
        case (addr)
            `WB_CSR_CRMD:   m_crmd = data;
            `WB_CSR_PRMD:   m_prmd = data;
            `WB_CSR_ESTAT:  m_estat[1:0] = data[1:0];  // swi bits
            `WB_CSR_ERA:    m_era = data;
            `WB_CSR_EENTRY: m_eentry = data;
            `WB_CSR_LLBCTL: if (data[1]) m_llbit = 1'b0;
            default: ;
        endcase
    endtask

    task automatic model_commit(inout entry_t e);
        logic [`WB_XLEN-1:0] old_crmd;
        logic [`WB_XLEN-1:0] old_prmd;
        logic [`WB_XLEN-1:0] old_era;
        logic [`WB_XLEN-1:0] old_eentry;
        wb_pkg::slot_t       s;
        old_crmd    = m_crmd;  // targets use state from before this bundle
        old_prmd    = m_prmd;
        old_era     = m_era;
        old_eentry  = m_eentry;
        e.exp_valid = 1'b0;
        e.exp_pc    = '0;
        if (e.ctl[1:0] == 2'b00) begin
            for (int i = 0; i < 2; i++) begin
                if (e.b.slot[i].valid && e.b.slot[i].is_ll && !e.ctl[2]) begin
                    m_llbit = 1'b1;
                end
            end
            for (int i = 0; i < 2; i++) begin
                s = e.b.slot[i];
                if (s.valid && !e.exp_valid) begin  // older redirect kills this slot
                    if (!s.exc && s.reg_we && s.reg_addr != 5'd0) begin
                        m_gpr[s.reg_addr] = s.reg_data;
                    end
                    if (!s.exc && s.csr_we) begin
                        model_csr_write(s.csr_addr, s.csr_data);
                    end
                    if (s.exc) begin
                        e.exp_valid    = 1'b1;
                        e.exp_pc       = old_eentry;
                        m_prmd[2:0]    = old_crmd[2:0];  // plv and ie
                        m_crmd[2:0]    = 3'b000;
                        m_era          = s.pc;
                        m_estat[22:16] = s.ecode;
                    end else if (s.ertn) begin
                        e.exp_valid = 1'b1;
                        e.exp_pc    = old_era;
                        m_crmd[2:0] = old_prmd[2:0];
                        m_llbit     = 1'b0;
                    end else if (s.priv) begin
                        e.exp_valid = 1'b1;
                        e.exp_pc    = s.pc + 32'd4;
                    end
                end
            end
        end
    endtask

    task automatic add_entry(input string name, input wb_pkg::slot_t s0,
                             input wb_pkg::slot_t s1, input logic [2:0] ctl,
                             input logic [`WB_CSR_AW:0] rd);
        entry_t e;
        e           = '0;
        e.b.slot[0] = s0;
        e.b.slot[1] = s1;
        e.ctl       = ctl;
        e.rd_csr    = rd[`WB_CSR_AW];
        e.rd_addr   = rd[`WB_CSR_AW-1:0];
        model_commit(e);
        e.exp_rd    = model_read(e.rd_csr, e.rd_addr);
        e.exp_llbit = m_llbit;
        table_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic build_table();
        wb_pkg::slot_t s0;
        wb_pkg::slot_t s1;
        for (int i = 0; i < `WB_NREG; i++) begin
            m_gpr[i] = '0;
        end
        m_crmd   = `WB_CRMD_RESET;
        m_prmd   = '0;
        m_era    = '0;
        m_estat  = '0;
        m_eentry = `WB_EENTRY_RESET;
        m_llbit  = 1'b0;

        add_entry("dual_write", reg_slot(5'd1, 32'h1c00_0000), reg_slot(5'd2, 32'h1c00_0004),
                  CTL_NONE, {RD_GPR, 14'd1});
        add_entry("dual_write_r2", '0, '0, CTL_NONE, {RD_GPR, 14'd2});
        add_entry("r0_write", reg_slot(5'd0, 32'h1c00_0008), reg_slot(5'd3, 32'h1c00_000c),
                  CTL_NONE, {RD_GPR, 14'd0});
        add_entry("same_reg", reg_slot(5'd4, 32'h1c00_0010), reg_slot(5'd4, 32'h1c00_0014),
                  CTL_NONE, {RD_GPR, 14'd4});
        s1      = reg_slot(5'd2, 32'h1c00_001c);
        s1.priv = 1'b1;
        add_entry("pause", reg_slot(5'd1, 32'h1c00_0018), s1, CTL_PAUSE, {RD_GPR, 14'd1});
        s1       = reg_slot(5'd2, 32'h1c00_0024);
        s1.exc   = 1'b1;
        s1.ecode = 7'h0a;
        add_entry("flush", reg_slot(5'd2, 32'h1c00_0020), s1, CTL_FLUSH, {RD_GPR, 14'd2});
        add_entry("crmd_write", csr_slot(`WB_CSR_CRMD, 32'h0000_000f),
                  reg_slot(5'd5, 32'h1c00_002c), CTL_NONE, {RD_CSR, `WB_CSR_CRMD});
        s0       = reg_slot(5'd6, 32'h1c00_0100);
        s0.exc   = 1'b1;
        s0.ecode = 7'h0b;
        add_entry("exc_slot0", s0, reg_slot(5'd7, 32'h1c00_0104), CTL_NONE,
                  {RD_CSR, `WB_CSR_ERA});
        add_entry("exc_estat", '0, '0, CTL_NONE, {RD_CSR, `WB_CSR_ESTAT});
        add_entry("exc_prmd", '0, '0, CTL_NONE, {RD_CSR, `WB_CSR_PRMD});
        add_entry("exc_crmd", '0, '0, CTL_NONE, {RD_CSR, `WB_CSR_CRMD});
        add_entry("exc_younger", '0, '0, CTL_NONE, {RD_GPR, 14'd7});
        add_entry("exc_own", '0, '0, CTL_NONE, {RD_GPR, 14'd6});
        s1       = reg_slot(5'd9, 32'h1c00_0114);
        s1.exc   = 1'b1;
        s1.ecode = 7'h0c;
        add_entry("exc_slot1", reg_slot(5'd6, 32'h1c00_0110), s1, CTL_NONE, {RD_GPR, 14'd6});
        s0       = reg_slot(5'd10, 32'h1c00_0120);
        s0.is_ll = 1'b1;
        add_entry("ll_uncached", s0, '0, CTL_UNCACHE, {RD_CSR, `WB_CSR_LLBCTL});
        add_entry("ll_cached", s0, '0, CTL_NONE, {RD_CSR, `WB_CSR_LLBCTL});
        add_entry("ertn_setup", csr_slot(`WB_CSR_PRMD, 32'h0000_0006),
                  csr_slot(`WB_CSR_ERA, 32'h1c00_2000), CTL_NONE, {RD_CSR, `WB_CSR_ERA});
        s0        = reg_slot(5'd11, 32'h1c00_0130);
        s0.reg_we = 1'b0;
        s0.ertn   = 1'b1;
        add_entry("ertn", s0, '0, CTL_NONE, {RD_CSR, `WB_CSR_CRMD});
        add_entry("ertn_llbit", '0, '0, CTL_NONE, {RD_CSR, `WB_CSR_LLBCTL});
        s0      = reg_slot(5'd8, 32'h1c00_0200);
        s0.priv = 1'b1;
        add_entry("priv_refetch", s0, reg_slot(5'd9, 32'h1c00_0204), CTL_NONE,
                  {RD_GPR, 14'd8});
        add_entry("priv_younger", '0, '0, CTL_NONE, {RD_GPR, 14'd9});
        add_entry("eentry_write", csr_slot(`WB_CSR_EENTRY, 32'h1c00_9000), '0, CTL_NONE,
                  {RD_CSR, `WB_CSR_EENTRY});
        s0       = reg_slot(5'd12, 32'h1c00_0300);
        s0.exc   = 1'b1;
        s0.ecode = 7'h0d;
        add_entry("exc_new_entry", s0, '0, CTL_NONE, {RD_CSR, `WB_CSR_ESTAT});
    endtask

    task automatic drive_entry(input entry_t e);
        commit  = e.b;
        pause   = e.ctl[0];
        flush   = e.ctl[1];
        uncache = e.ctl[2];
        if (e.rd_csr) begin
            csr_raddr = e.rd_addr;
        end else begin
            gpr_raddr = e.rd_addr[4:0];
        end
    endtask

    task automatic drive_idle();
        commit  = '0;
        pause   = 1'b0;
        flush   = 1'b0;
        uncache = 1'b0;
    endtask

    task automatic wait_reset(output logic released);
        int waited;
        waited = 0;
        while (arst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        released = (arst_n === 1'b1);
    endtask

    task automatic run_table();
        entry_t              e;
        int                  err_before;
        logic [`WB_XLEN-1:0] rd_val;
        for (int i = 0; i < table_q.size(); i++) begin
            e          = table_q[i];
            err_before = n_err;
            drive_entry(e);
            @(posedge clk);
            #1;
            drive_idle();
            if (redirect.valid !== e.exp_valid) begin
                $display("FAILED at %0d ns: redirect_o.valid got %b expected %b",
                         $time, redirect.valid, e.exp_valid);
                n_err++;
            end
            if (e.exp_valid && redirect.pc !== e.exp_pc) begin
                $display("FAILED at %0d ns: redirect_o.pc got %h expected %h",
                         $time, redirect.pc, e.exp_pc);
                n_err++;
            end
            @(posedge clk);
            #1;
            rd_val = e.rd_csr ? csr_rdata : gpr_rdata;
            if (rd_val !== e.exp_rd) begin
                $display("FAILED at %0d ns: %s got %h expected %h", $time,
                         e.rd_csr ? "csr_rdata_o" : "gpr_rdata_o", rd_val, e.exp_rd);
                n_err++;
            end
            if (llbit !== e.exp_llbit) begin
                $display("FAILED at %0d ns: llbit_o got %b expected %b",
                         $time, llbit, e.exp_llbit);
                n_err++;
            end
            if (n_err != err_before) begin
                n_bad_tests++;
            end
            $display("test %2d %-16s %s", i, name_q[i], (n_err == err_before) ? "ok" : "failed");
        end
    endtask

    initial begin
        logic released;
        drive_idle();
        gpr_raddr = '0;
        csr_raddr = '0;
        build_table();
        wait_reset(released);
        if (!released) begin
            $display("timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
            $display("Test failures found");
            $finish;
        end else begin
            #1;
            run_table();
            $display("%0d tests, %0d ok, %0d failed, %0d mismatches", table_q.size(),
                     table_q.size() - n_bad_tests, n_bad_tests, n_err);
            if (n_err == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
